/* files.f */
+incdir+src
src/exu_pkg.sv
src/cmd_receiver.sv
src/reg_file.sv
src/op_decoder.sv
src/alu.sv
src/result_sender.sv
src/exu_top.sv
verif/exu_tb.sv

/* verif/exu_tb.sv */
`default_nettype none

`include "exu_config.svh"

module exu_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import exu_pkg::*;

	localparam int CLK_PERIOD     = 100;
	localparam int RESET_CYCLES   = 10;
	localparam int HS_TIMEOUT     = 50;
	localparam int CYCLES_PER_CMD = 100;
	// Commands issued over all tests
	localparam int NUM_CMDS       = 100;

	localparam logic [2:0] F3_ADD  = 3'd0;
	localparam logic [2:0] F3_SLL  = 3'd1;
	localparam logic [2:0] F3_SLT  = 3'd2;
	localparam logic [2:0] F3_SLTU = 3'd3;
	localparam logic [2:0] F3_XOR  = 3'd4;
	localparam logic [2:0] F3_SR   = 3'd5;
	localparam logic [2:0] F3_OR   = 3'd6;
	localparam logic [2:0] F3_AND  = 3'd7;

	logic        clk;
	logic        rst_n;
	logic        in_req;
	exu_cmd_t    in_cmd;
	logic        in_ack;
	logic        out_req;
	exu_result_t out_res;
	logic        out_ack;

	logic [`EXU_XLEN-1:0] shadow [`EXU_NREGS];
	int                   errors;
	integer               seed;

	exu_top dut0 (
		.clk     (clk),
		.rst_n   (rst_n),
		.in_req  (in_req),
		.in_cmd  (in_cmd),
		.in_ack  (in_ack),
		.out_req (out_req),
		.out_res (out_res),
		.out_ack (out_ack)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(CLK_PERIOD * (RESET_CYCLES + CYCLES_PER_CMD * NUM_CMDS));
		$display("Watchdog expired before the tests completed");
		$display("ERRORS FOUND");
		$finish;
	end

	function automatic exu_cmd_t make_cmd(input cmd_kind_t kind, input logic [2:0] funct3,
			input logic alt, input logic [4:0] rd, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [`EXU_XLEN-1:0] imm);
		exu_cmd_t c;
		c.kind   = kind;
		c.funct3 = funct3;
		c.alt    = alt;
		c.rd     = rd;
		c.rs1    = rs1;
		c.rs2    = rs2;
		c.imm    = imm;
		return c;
	endfunction

	// Expected result from the operation rules and the shadow registers
	function automatic logic [`EXU_XLEN-1:0] ref_value(input exu_cmd_t c);
		logic [`EXU_XLEN-1:0] a;
		logic [`EXU_XLEN-1:0] b;
		a = shadow[c.rs1];
		b = (c.kind == KIND_REG) ? shadow[c.rs2] : c.imm;
		if (c.kind == KIND_LUI) begin
			return c.imm;
		end
		case ({c.alt, c.funct3})
			4'b1000: return a - b;
			4'b0001: return a << b[4:0];
			4'b0010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			4'b0011: return (a < b) ? 32'd1 : 32'd0;
			4'b0100: return a ^ b;
			4'b0101: return a >> b[4:0];
			4'b1101: return $unsigned($signed(a) >>> b[4:0]);
			4'b0110: return a | b;
			4'b0111: return a & b;
			default: return a + b;
		endcase
	endfunction

	function automatic logic ref_illegal(input exu_cmd_t c);
		if (c.kind == KIND_LUI || !c.alt || c.funct3 == F3_SR) begin
			return 1'b0;
		end
		return !(c.kind == KIND_REG && c.funct3 == F3_ADD);
	endfunction

	task automatic wait_in_ack(input logic level);
		int n;
		n = 0;
		@(negedge clk);
		while (in_ack !== level && n < HS_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		assert (in_ack === level) else begin
			$display("Timeout at %0t waiting for in_ack to become %0b", $time, level);
			errors++;
		end
	endtask

	task automatic wait_out_req(input logic level);
		int n;
		n = 0;
		@(negedge clk);
		while (out_req !== level && n < HS_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		assert (out_req === level) else begin
			$display("Timeout at %0t waiting for out_req to become %0b", $time, level);
			errors++;
		end
	endtask

	task automatic put_cmd(input exu_cmd_t c);
		@(posedge clk);
		in_cmd <= c;
		in_req <= 1'b1;
	endtask

	task automatic finish_input();
		wait_in_ack(1'b1);
		@(posedge clk);
		in_req <= 1'b0;
		wait_in_ack(1'b0);
	endtask

	task automatic take_result(output exu_result_t r);
		wait_out_req(1'b1);
		r = out_res;
		@(posedge clk);
		out_ack <= 1'b1;
		wait_out_req(1'b0);
		@(posedge clk);
		out_ack <= 1'b0;
	endtask

	task automatic check_result(input exu_result_t r, input logic [4:0] rd,
			input logic [`EXU_XLEN-1:0] value, input logic illegal);
		assert (r.rd == rd) else begin
			$display("FAILED at %0t: out_res.rd expected %0d actual %0d", $time, rd, r.rd);
			errors++;
		end
		assert (r.illegal == illegal) else begin
			$display("FAILED at %0t: out_res.illegal expected %0b actual %0b",
				$time, illegal, r.illegal);
			errors++;
		end
		// Value of an illegal command is undefined
		assert (illegal || r.value == value) else begin
			$display("FAILED at %0t: out_res.value expected %h actual %h",
				$time, value, r.value);
			errors++;
		end
	endtask

	task automatic commit(input logic [4:0] rd, input logic [`EXU_XLEN-1:0] value,
			input logic illegal);
		if (!illegal && rd != 5'd0) begin
			shadow[rd] = value;
		end
	endtask

	task automatic run_cmd(input exu_cmd_t c);
		exu_result_t          r;
		logic [`EXU_XLEN-1:0] exp_val;
		logic                 exp_ill;
		exp_val = ref_value(c);
		exp_ill = ref_illegal(c);
		put_cmd(c);
		finish_input();
		take_result(r);
		check_result(r, c.rd, exp_val, exp_ill);
		commit(c.rd, exp_val, exp_ill);
	endtask

	task automatic load_reg(input logic [4:0] rd, input logic [`EXU_XLEN-1:0] value);
		run_cmd(make_cmd(KIND_LUI, F3_ADD, 1'b0, rd, 5'd0, 5'd0, value));
	endtask

	task automatic reg_op(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2);
		run_cmd(make_cmd(KIND_REG, f3, alt, rd, rs1, rs2, '0));
	endtask

	task automatic imm_op(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [`EXU_XLEN-1:0] imm);
		run_cmd(make_cmd(KIND_IMM, f3, alt, rd, rs1, 5'd0, imm));
	endtask

	task automatic test_seed_regs();
		load_reg(5'd1, 32'h1234_5678);
		load_reg(5'd2, 32'hcafe_f00d);
		load_reg(5'd3, 32'h0000_0001);
		load_reg(5'd4, 32'h8000_0000);
		// Reported, but x0 keeps reading zero
		load_reg(5'd0, 32'hdead_beef);
		reg_op(F3_ADD, 1'b0, 5'd5, 5'd1, 5'd0);
		reg_op(F3_ADD, 1'b0, 5'd6, 5'd0, 5'd2);
		reg_op(F3_ADD, 1'b0, 5'd7, 5'd0, 5'd0);
		imm_op(F3_ADD, 1'b0, 5'd8, 5'd3, 32'd0);
		reg_op(F3_ADD, 1'b0, 5'd9, 5'd4, 5'd0);
	endtask

	task automatic test_add_sub();
		load_reg(5'd1, 32'hffff_ffff);
		load_reg(5'd2, 32'h0000_0001);
		load_reg(5'd3, 32'h8000_0000);
		reg_op(F3_ADD, 1'b0, 5'd4, 5'd1, 5'd2);
		reg_op(F3_ADD, 1'b1, 5'd5, 5'd0, 5'd2);
		reg_op(F3_ADD, 1'b1, 5'd6, 5'd2, 5'd1);
		imm_op(F3_ADD, 1'b0, 5'd7, 5'd1, 32'd5);
		reg_op(F3_ADD, 1'b0, 5'd8, 5'd3, 5'd3);
		reg_op(F3_ADD, 1'b1, 5'd9, 5'd3, 5'd2);
		imm_op(F3_ADD, 1'b0, 5'd10, 5'd2, 32'hffff_ffff);
	endtask

	task automatic compare_pair(input logic [`EXU_XLEN-1:0] a, input logic [`EXU_XLEN-1:0] b);
		load_reg(5'd1, a);
		load_reg(5'd2, b);
		reg_op(F3_SLT, 1'b0, 5'd3, 5'd1, 5'd2);
		reg_op(F3_SLTU, 1'b0, 5'd4, 5'd1, 5'd2);
		imm_op(F3_SLT, 1'b0, 5'd5, 5'd1, b);
		imm_op(F3_SLTU, 1'b0, 5'd6, 5'd1, b);
	endtask

	task automatic test_compare();
		compare_pair(32'h8000_0000, 32'h0000_0001);
		compare_pair(32'h0000_0001, 32'h8000_0000);
		compare_pair(32'h7fff_ffff, 32'h8000_0000);
		compare_pair(32'hffff_ffff, 32'h0000_0000);
		compare_pair(32'h8000_0000, 32'h7fff_ffff);
	endtask

	task automatic test_shift();
		load_reg(5'd1, 32'h8000_0f0f);
		load_reg(5'd2, 32'h0000_0004);
		// Only the low five bits, 3, count
		load_reg(5'd3, 32'hffff_ffe3);
		reg_op(F3_SLL, 1'b0, 5'd4, 5'd1, 5'd2);
		reg_op(F3_SR, 1'b0, 5'd5, 5'd1, 5'd2);
		reg_op(F3_SR, 1'b1, 5'd6, 5'd1, 5'd2);
		reg_op(F3_SLL, 1'b0, 5'd7, 5'd1, 5'd3);
		reg_op(F3_SR, 1'b0, 5'd8, 5'd1, 5'd3);
		reg_op(F3_SR, 1'b1, 5'd9, 5'd1, 5'd3);
		imm_op(F3_SLL, 1'b0, 5'd10, 5'd1, 32'd31);
		imm_op(F3_SR, 1'b0, 5'd11, 5'd1, 32'h25);
		imm_op(F3_SR, 1'b1, 5'd12, 5'd1, 32'd31);
		imm_op(F3_SR, 1'b1, 5'd13, 5'd1, 32'd4);
	endtask

	task automatic test_logic();
		int         op;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		for (int i = 1; i <= 10; i++) begin
			load_reg(i[4:0], $random(seed));
		end
		for (int i = 0; i < 20; i++) begin
			op  = $unsigned($random(seed)) % 3;
			rd  = 5'd1 + 5'($unsigned($random(seed)) % 10);
			rs1 = 5'd1 + 5'($unsigned($random(seed)) % 10);
			rs2 = 5'd1 + 5'($unsigned($random(seed)) % 10);
			f3  = (op == 0) ? F3_XOR : ((op == 1) ? F3_OR : F3_AND);
			if (i % 4 == 3) begin
				imm_op(f3, 1'b0, rd, rs1, $random(seed));
			end else begin
				reg_op(f3, 1'b0, rd, rs1, rs2);
			end
		end
	endtask

	task automatic test_illegal_stall();
		exu_cmd_t             a;
		exu_cmd_t             b;
		exu_result_t          r;
		logic [`EXU_XLEN-1:0] va;
		logic [`EXU_XLEN-1:0] vb;
		logic                 ia;
		logic                 ib;
		load_reg(5'd9, 32'h0bad_c0de);
		reg_op(F3_XOR, 1'b1, 5'd9, 5'd1, 5'd2);
		imm_op(F3_ADD, 1'b1, 5'd9, 5'd1, 32'd7);
		imm_op(F3_OR, 1'b1, 5'd9, 5'd1, 32'd7);
		reg_op(F3_ADD, 1'b0, 5'd10, 5'd9, 5'd0);

		// Second command reads the result of the first
		a  = make_cmd(KIND_IMM, F3_ADD, 1'b0, 5'd11, 5'd9, 5'd0, 32'h100);
		b  = make_cmd(KIND_REG, F3_ADD, 1'b0, 5'd12, 5'd11, 5'd11, '0);
		va = ref_value(a);
		ia = ref_illegal(a);
		put_cmd(a);
		finish_input();
		commit(a.rd, va, ia);
		vb = ref_value(b);
		ib = ref_illegal(b);
		put_cmd(b);
		repeat (8) begin
			@(negedge clk);
			assert (in_ack == 1'b0) else begin
				$display("in_ack rose at %0t while the previous output was unacknowledged",
					$time);
				errors++;
			end
		end
		take_result(r);
		check_result(r, a.rd, va, ia);
		finish_input();
		take_result(r);
		check_result(r, b.rd, vb, ib);
		commit(b.rd, vb, ib);
	endtask

	initial begin
		rst_n   = 1'b0;
		in_req  = 1'b0;
		in_cmd  = '0;
		out_ack = 1'b0;
		errors  = 0;
		seed    = 75;
		for (int k = 0; k < `EXU_NREGS; k++) begin
			shadow[k] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		test_seed_regs();
		test_add_sub();
		test_compare();
		test_shift();
		test_logic();
		test_illegal_stall();

		$display("Test run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src/exu_top.sv */
`default_nettype none

`include "exu_config.svh"

module exu_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_req,
	input  exu_pkg::exu_cmd_t    in_cmd,
	output logic                 in_ack,
	output logic                 out_req,
	output exu_pkg::exu_result_t out_res,
	input  logic                 out_ack
);

	import exu_pkg::*;

	exu_cmd_t                cmd;
	logic                    cmd_valid;
	logic                    cmd_release;
	logic [`EXU_XLEN-1:0]    rd1;
	logic [`EXU_XLEN-1:0]    rd2;
	alu_op_t                 alu_op;
	logic [`EXU_XLEN-1:0]    src1;
	logic [`EXU_XLEN-1:0]    src2;
	logic                    illegal;
	logic [`EXU_XLEN-1:0]    alu_res;
	logic                    wr_en;
	logic [`EXU_RADDR_W-1:0] wr_addr;
	logic [`EXU_XLEN-1:0]    wr_data;

	cmd_receiver u_cmd_receiver (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_req      (in_req),
		.in_cmd      (in_cmd),
		.in_ack      (in_ack),
		.cmd_release (cmd_release),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd)
	);

	reg_file u_reg_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs1     (cmd.rs1),
		.rs2     (cmd.rs2),
		.rd1     (rd1),
		.rd2     (rd2),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data)
	);

	op_decoder u_op_decoder (
		.cmd     (cmd),
		.rd1     (rd1),
		.rd2     (rd2),
		.alu_op  (alu_op),
		.src1    (src1),
		.src2    (src2),
		.illegal (illegal)
	);

	alu u_alu (
		.src1 (src1),
		.src2 (src2),
		.ctrl (alu_op),
		.res  (alu_res)
	);

	result_sender u_result_sender (
		.clk         (clk),
		.rst_n       (rst_n),
		.cmd_valid   (cmd_valid),
		.rd          (cmd.rd),
		.value       (alu_res),
		.illegal     (illegal),
		.cmd_release (cmd_release),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.out_req     (out_req),
		.out_ack     (out_ack),
		.out_res     (out_res)
	);

endmodule

`default_nettype wire

/* src/result_sender.sv */
`default_nettype none

`include "exu_config.svh"

module result_sender (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    cmd_valid,
	input  logic [`EXU_RADDR_W-1:0] rd,
	input  logic [`EXU_XLEN-1:0]    value,
	input  logic                    illegal,
	output logic                    cmd_release,
	output logic                    wr_en,
	output logic [`EXU_RADDR_W-1:0] wr_addr,
	output logic [`EXU_XLEN-1:0]    wr_data,
	output logic                    out_req,
	input  logic                    out_ack,
	output exu_pkg::exu_result_t    out_res
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQ,
		S_WAIT_LOW
	} state_t;

	state_t state;

	assign cmd_release = cmd_valid && (state == S_IDLE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (cmd_release) begin
						state <= S_REQ;
					end
				end
				S_REQ: begin
					if (out_ack) begin
						state <= S_WAIT_LOW;
					end
				end
				S_WAIT_LOW: begin
					if (!out_ack) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_release) begin
			out_res.rd      <= rd;
			out_res.value   <= value;
			out_res.illegal <= illegal;
		end
	end

	// Single-cycle write, suppressed for illegal commands
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_en <= 1'b0;
		end else begin
			wr_en <= cmd_release && !illegal;
		end
	end

	assign wr_addr = out_res.rd;
	assign wr_data = out_res.value;
	assign out_req = (state == S_REQ);

	out_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(out_ack) |-> out_req)
		else $error("out_ack rose while out_req was low");

endmodule

`default_nettype wire

/* src/alu.sv */
`default_nettype none

`include "exu_config.svh"

module alu (
	input  logic [`EXU_XLEN-1:0] src1,
	input  logic [`EXU_XLEN-1:0] src2,
	input  exu_pkg::alu_op_t     ctrl,
	output logic [`EXU_XLEN-1:0] res
);

	import exu_pkg::*;

	localparam int XLEN    = `EXU_XLEN;
	localparam int SHAMT_W = $clog2(XLEN);

	// Shared adder, low bit of the widened operands is the carry-in
	logic              subtract;
	logic [XLEN:0]     add_a;
	logic [XLEN:0]     add_b;
	logic [XLEN+1:0]   add_sum;
	logic [XLEN-1:0]   add_res;

	assign subtract = (ctrl == ALU_SUB) || (ctrl == ALU_SLT) || (ctrl == ALU_SLTU);
	assign add_a    = {src1, 1'b1};
	assign add_b    = subtract ? ~{src2, 1'b0} : {src2, 1'b0};
	assign add_sum  = {1'b0, add_a} + {1'b0, add_b};
	assign add_res  = add_sum[XLEN:1];

	logic overflow;
	logic lt_signed;
	logic lt_unsigned;
	logic cmp_res;

	// Operand signs differ and the difference takes the sign of src2
	assign overflow    = (src1[XLEN-1] != src2[XLEN-1]) && (add_res[XLEN-1] != src1[XLEN-1]);
	assign lt_signed   = add_res[XLEN-1] ^ overflow;
	// Borrow out of the subtraction
	assign lt_unsigned = ~add_sum[XLEN+1];
	assign cmp_res     = (ctrl == ALU_SLTU) ? lt_unsigned : lt_signed;

	// One right shifter, left shifts go through bit reversal
	logic [SHAMT_W-1:0]   shamt;
	logic [XLEN-1:0]      shift_in;
	logic                 shift_fill;
	logic signed [XLEN:0] shift_ext;
	logic signed [XLEN:0] shift_wide;
	logic [XLEN-1:0]      shift_out;

	assign shamt = src2[SHAMT_W-1:0];

	always_comb begin
		for (int i = 0; i < XLEN; i++) begin
			shift_in[i] = (ctrl == ALU_SLL) ? src1[XLEN-1-i] : src1[i];
		end
	end

	assign shift_fill = (ctrl == ALU_SRA) && src1[XLEN-1];
	assign shift_ext  = {shift_fill, shift_in};
	assign shift_wide = shift_ext >>> shamt;
	assign shift_out  = shift_wide[XLEN-1:0];

	logic [XLEN-1:0] logic_res;

	always_comb begin
		case (ctrl)
			ALU_OR:  logic_res = src1 | src2;
			ALU_XOR: logic_res = src1 ^ src2;
			default: logic_res = src1 & src2;
		endcase
	end

	always_comb begin
		case (ctrl)
			ALU_SLT, ALU_SLTU: begin
				res = {{(XLEN-1){1'b0}}, cmp_res};
			end
			ALU_SLL: begin
				for (int i = 0; i < XLEN; i++) begin
					res[i] = shift_out[XLEN-1-i];
				end
			end
			ALU_SRL, ALU_SRA: begin
				res = shift_out;
			end
			ALU_AND, ALU_OR, ALU_XOR: begin
				res = logic_res;
			end
			default: begin
				res = add_res;
			end
		endcase
	end

	cmp_order: assert final (!(ctrl inside {ALU_SLT, ALU_SLTU}) || res[0] ==
			((ctrl == ALU_SLT) ? ($signed(src1) < $signed(src2)) : (src1 < src2)))
		else $error("compare result %h disagrees with the operand order", res);

endmodule

`default_nettype wire

/* src/op_decoder.sv */
`default_nettype none

`include "exu_config.svh"

module op_decoder (
	input  exu_pkg::exu_cmd_t    cmd,
	input  logic [`EXU_XLEN-1:0] rd1,
	input  logic [`EXU_XLEN-1:0] rd2,
	output exu_pkg::alu_op_t     alu_op,
	output logic [`EXU_XLEN-1:0] src1,
	output logic [`EXU_XLEN-1:0] src2,
	output logic                 illegal
);

	import exu_pkg::*;

	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SRL = 3'b101;

	logic alt_on_add;
	logic alt_on_srl;

	assign alt_on_add = cmd.alt && (cmd.funct3 == F3_ADD);
	assign alt_on_srl = cmd.alt && (cmd.funct3 == F3_SRL);

	always_comb begin
		src1    = rd1;
		src2    = cmd.imm;
		alu_op  = alu_op_t'({cmd.alt, cmd.funct3});
		illegal = 1'b0;
		case (cmd.kind)
			KIND_REG: begin
				src2    = rd2;
				// Only SUB and SRA use the alternate bit
				illegal = cmd.alt && !alt_on_add && !alt_on_srl;
			end
			KIND_IMM: begin
				// There is no subtract-immediate
				illegal = cmd.alt && !alt_on_srl;
			end
			KIND_LUI: begin
				src1   = '0;
				alu_op = ALU_ADD;
			end
			default: begin
				illegal = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

/* src/reg_file.sv */
`default_nettype none

`include "exu_config.svh"

module reg_file (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [`EXU_RADDR_W-1:0] rs1,
	input  logic [`EXU_RADDR_W-1:0] rs2,
	output logic [`EXU_XLEN-1:0]    rd1,
	output logic [`EXU_XLEN-1:0]    rd2,
	input  logic                    wr_en,
	input  logic [`EXU_RADDR_W-1:0] wr_addr,
	input  logic [`EXU_XLEN-1:0]    wr_data
);

	// x0 has no storage
	logic [`EXU_XLEN-1:0] regs [1:`EXU_NREGS-1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < `EXU_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	always_comb begin
		if (rs1 == '0) begin
			rd1 = '0;
		end else begin
			rd1 = regs[rs1];
		end
	end

	always_comb begin
		if (rs2 == '0) begin
			rd2 = '0;
		end else begin
			rd2 = regs[rs2];
		end
	end

	wr_known: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> !$isunknown({wr_addr, wr_data}))
		else $error("write with unknown address or data");

endmodule

`default_nettype wire

/* src/cmd_receiver.sv */
`default_nettype none

module cmd_receiver (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_req,
	input  exu_pkg::exu_cmd_t in_cmd,
	output logic              in_ack,
	input  logic              cmd_release,
	output logic              cmd_valid,
	output exu_pkg::exu_cmd_t cmd
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_HOLD,
		S_ACK
	} state_t;

	state_t state;
	state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE: begin
				if (in_req) begin
					state_nxt = S_HOLD;
				end
			end
			// Wait for the sender to take the command
			S_HOLD: begin
				if (cmd_release) begin
					state_nxt = S_ACK;
				end
			end
			S_ACK: begin
				if (!in_req) begin
					state_nxt = S_IDLE;
				end
			end
			default: state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Loaded on acceptance, held until the next request
	always_ff @(posedge clk) begin
		if (state == S_IDLE && in_req) begin
			cmd <= in_cmd;
		end
	end

	assign cmd_valid = (state == S_HOLD);
	assign in_ack    = (state == S_ACK);

	ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(in_ack) |-> in_req)
		else $error("in_ack rose while in_req was low");

	release_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_release |-> cmd_valid)
		else $error("release without a held command");

endmodule

`default_nettype wire

/* src/exu_pkg.sv */
`default_nettype none

`include "exu_config.svh"

package exu_pkg;

	// Encoding is {funct7 alt bit, funct3}
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SUB  = 4'b1000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_SRA  = 4'b1101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111
	} alu_op_t;

	typedef enum logic [1:0] {
		KIND_REG = 2'd0,
		KIND_IMM = 2'd1,
		KIND_LUI = 2'd2
	} cmd_kind_t;

	// Host command, 53 bits
	typedef struct packed {
		cmd_kind_t               kind;
		logic [2:0]              funct3;
		logic                    alt;
		logic [`EXU_RADDR_W-1:0] rd;
		logic [`EXU_RADDR_W-1:0] rs1;
		logic [`EXU_RADDR_W-1:0] rs2;
		logic [`EXU_XLEN-1:0]    imm;
	} exu_cmd_t;

	// Reported result, 38 bits
	typedef struct packed {
		logic [`EXU_RADDR_W-1:0] rd;
		logic [`EXU_XLEN-1:0]    value;
		logic                    illegal;
	} exu_result_t;

endpackage

`default_nettype wire

/* src/exu_config.svh */
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// Datapath width in bits
`define EXU_XLEN 32

// Architectural registers, x0 included
`define EXU_NREGS 32

// Width of a register index
`define EXU_RADDR_W 5

`endif
